//--- compile.f
+incdir+hdl
hdl/smc_lite_pkg.sv
hdl/smc_cfg_if.sv
hdl/smc_apb_lite_if.sv
hdl/smc_cfreg_lite.sv
hdl/smc_access_fsm.sv
hdl/smc_lite_top.sv
bench/sram_model.sv
bench/smc_lite_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the smc_lite testbench with Verilator, log in sim.log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f compile.f --top-module smc_lite_tb -o sim_smc_lite

./obj_dir/sim_smc_lite 2>&1 | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
  echo "simulation ended without a result line"
  exit 1
fi
echo "simulation passed"

//--- bench/smc_lite_tb.sv
// Static memory controller testbench
`timescale 1ns/10ps
`default_nettype none

`include "smc_lite_settings.svh"

module smc_lite_tb;

  localparam int TIMEOUT = 50;                                // Cycles per wait
  localparam smc_lite_pkg::data_t CFG_MASK = 32'h8000_03ff;   // Enable, turn, waits

  logic pclk = 1'b0;
  logic reset;
  logic psel, penable, pwrite;
  logic [4:0] paddr;
  smc_lite_pkg::data_t pwdata, prdata;
  logic host_req, host_write, host_ready, host_done;
  smc_lite_pkg::addr_t host_addr, mem_addr;
  smc_lite_pkg::data_t host_wdata, host_rdata, mem_wdata, mem_rdata;
  logic mem_cs_n, mem_oe_n, mem_we_n;

  // Shadow state
  smc_lite_pkg::cfg_t cur_cfg;                          // Expected register 0
  smc_lite_pkg::data_t shadow [smc_lite_pkg::addr_t];   // Written SRAM words
  logic exp_write_q [$];                                // One per open access
  smc_lite_pkg::data_t exp_data_q [$];
  int seed = 7;
  int errors = 0, n_checks = 0, n_tests = 0, test_mark = 0, n_issued = 0;

  always #2 pclk = ~pclk;   // 4 ns period

  smc_lite_top dut0 (.*);
  sram_model i_sram (.*);

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------
  function automatic smc_lite_pkg::data_t expected_rdata(smc_lite_pkg::addr_t a);
    return shadow[a];                            // Last word written there
  endfunction

  function automatic int expected_strobe_cycles(smc_lite_pkg::cfg_t c, logic wr);
    return (wr ? int'(c.wr_wait) : int'(c.rd_wait)) + 1;
  endfunction

  function automatic int expected_done_cycles(smc_lite_pkg::cfg_t c, logic wr);
    return (wr ? int'(c.wr_wait) : int'(c.rd_wait)) + 2;
  endfunction

  function automatic int expected_ready_cycles(smc_lite_pkg::cfg_t c);
    return int'(c.turn) + 1;                     // Turnaround plus the done cycle
  endfunction

  // ----------------------------------------------------------------------
  // Compare and report
  // ----------------------------------------------------------------------
  task automatic check_data(input string name, input smc_lite_pkg::data_t exp,
                            input smc_lite_pkg::data_t act);
    n_checks++;
    if (act !== exp)
    begin
      errors++;
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_cfg(input string name, input smc_lite_pkg::cfg_t exp,
                           input smc_lite_pkg::data_t act);
    smc_lite_pkg::cfg_t a;
    a = smc_lite_pkg::cfg_t'(act);
    n_checks++;
    if (a !== exp)   // Whole word, so stray reserved bits count too
    begin
      errors++;
      $display("[ERROR] %0t %s expected %h actual %h (en/turn/wr/rd %0d/%0d/%0d/%0d)",
               $time, name, exp, act, a.enable, a.turn, a.wr_wait, a.rd_wait);
    end
  endtask

  task automatic check_count(input string name, input smc_lite_pkg::count_t exp,
                             input smc_lite_pkg::count_t act);
    n_checks++;
    if (act !== exp)
    begin
      errors++;
      $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_cycles(input string name, input int exp, input int act);
    n_checks++;
    if (act != exp)
    begin
      errors++;
      $display("[ERROR] %0t %s expected %0d cycles actual %0d cycles", $time, name, exp, act);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("timeout at %0t: %s did not arrive within %0d cycles", $time, what, TIMEOUT);
  endtask

  task automatic end_test(input string name);
    n_tests++;
    $display("test %0d %-26s %s", n_tests, name, (errors == test_mark) ? "pass" : "fail");
    test_mark = errors;
  endtask

  // Read data checked in the done cycle, away from the clock edge
  always @(negedge pclk)
  begin : p_compare
    logic is_wr;
    smc_lite_pkg::data_t exp;
    if (!reset && host_done === 1'b1)
    begin
      if (exp_write_q.size() == 0)
      begin
        errors++;
        $display("host_done at %0t with no access outstanding", $time);
      end
      else
      begin
        is_wr = exp_write_q.pop_front();
        exp = exp_data_q.pop_front();
        if (!is_wr)
          check_data("host_rdata", exp, host_rdata);
      end
    end
  end

  // ----------------------------------------------------------------------
  // Bus tasks, inputs change 1 ns after the rising edge
  // ----------------------------------------------------------------------
  task automatic step();
    @(posedge pclk);
    #1;
  endtask

  task automatic apb_write(input logic [4:0] addr, input smc_lite_pkg::data_t data);
    psel = 1'b1;                                 // Setup phase
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    step();
    penable = 1'b1;                              // Access phase
    step();
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    if (addr == `SMC_REG_CONFIG)
      cur_cfg = smc_lite_pkg::cfg_t'(data & CFG_MASK);
  endtask

  task automatic apb_read(input logic [4:0] addr, output smc_lite_pkg::data_t data);
    psel = 1'b1;
    pwrite = 1'b0;
    paddr = addr;
    step();
    penable = 1'b1;
    #1 data = prdata;                            // Combinational in access phase
    step();
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic wait_ready(output logic ok);
    int n;
    n = 0;
    while (host_ready !== 1'b1 && n < TIMEOUT)
    begin
      step();
      n++;
    end
    ok = (host_ready === 1'b1);
    if (!ok)
      report_timeout("host_ready");
  endtask

  // One access, latencies counted from the drive edge
  task automatic host_access(input logic wr, input smc_lite_pkg::addr_t addr,
                             input smc_lite_pkg::data_t wdata);
    logic ok;
    int n;
    int strobe;
    wait_ready(ok);
    if (!ok)
      return;
    host_req = 1'b1;
    host_write = wr;
    host_addr = addr;
    host_wdata = wdata;
    exp_write_q.push_back(wr);
    exp_data_q.push_back(wr ? wdata : expected_rdata(addr));
    if (wr)
      shadow[addr] = wdata;
    n_issued++;
    step();
    host_req = 1'b0;
    n = 1;
    strobe = 0;
    while (host_done !== 1'b1 && n < TIMEOUT)
    begin
      if (mem_cs_n === 1'b0 && (wr ? mem_we_n : mem_oe_n) === 1'b0)
        strobe++;                                // Select and matching strobe low
      step();
      n++;
    end
    if (host_done !== 1'b1)
      report_timeout("host_done");
    else
    begin
      check_cycles("host_done latency", expected_done_cycles(cur_cfg, wr), n);
      check_cycles(wr ? "mem_we_n low" : "mem_oe_n low",
                   expected_strobe_cycles(cur_cfg, wr), strobe);
    end
    n = 0;
    while (host_ready !== 1'b1 && n < TIMEOUT)
    begin
      step();
      n++;
    end
    if (host_ready !== 1'b1)
      report_timeout("host_ready after done");
    else
      check_cycles("host_ready latency", expected_ready_cycles(cur_cfg), n);
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial
  begin : p_main
    smc_lite_pkg::data_t rd;
    smc_lite_pkg::addr_t addrs [20];
    smc_lite_pkg::addr_t a;
    logic ok;
    int n;
    reset = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    host_req = 1'b0;
    host_write = 1'b0;
    host_addr = '0;
    host_wdata = '0;
    cur_cfg = '0;
    cur_cfg.enable = 1'b1;
    cur_cfg.turn = `SMC_RST_TURN;
    cur_cfg.wr_wait = `SMC_RST_WR_WAIT;
    cur_cfg.rd_wait = `SMC_RST_RD_WAIT;
    repeat (3) @(posedge pclk);
    #1 reset = 1'b0;

    apb_read(`SMC_REG_CONFIG, rd);
    check_cfg("prdata config", cur_cfg, rd);
    apb_read(`SMC_REG_STATUS, rd);
    check_data("prdata status", '0, rd);
    apb_read(5'h08, rd);                         // Unmapped
    check_data("prdata unmapped", '0, rd);
    end_test("reset values");

    apb_write(`SMC_REG_CONFIG, 32'hfedc_b321);   // Junk in reserved bits
    apb_read(`SMC_REG_CONFIG, rd);
    check_cfg("prdata config", cur_cfg, rd);
    end_test("config readback");

    for (int i = 0; i < 20; i++)
    begin
      addrs[i] = smc_lite_pkg::addr_t'($random(seed));
      host_access(1'b1, addrs[i], smc_lite_pkg::data_t'($random(seed)));
    end
    for (int i = 0; i < 20; i++)
      host_access(1'b0, addrs[i], '0);
    end_test("write then read");

    apb_write(`SMC_REG_CONFIG, 32'h8000_0050);   // rd 0, wr 5, turn 0
    a = smc_lite_pkg::addr_t'($random(seed));
    host_access(1'b1, a, smc_lite_pkg::data_t'($random(seed)));
    host_access(1'b0, a, '0);
    apb_write(`SMC_REG_CONFIG, 32'h8000_0217);   // rd 7, wr 1, turn 2
    host_access(1'b1, a, smc_lite_pkg::data_t'($random(seed)));
    host_access(1'b0, a, '0);
    end_test("latency");

    apb_read(`SMC_REG_STATUS, rd);
    check_count("status count", smc_lite_pkg::count_t'(n_issued), rd[15:0]);
    check_data("prdata status", {16'h0000, smc_lite_pkg::count_t'(n_issued)}, rd);
    end_test("status");

    apb_write(`SMC_REG_CONFIG, 32'h0000_0111);   // Enable cleared
    n = 0;
    repeat (10)
    begin
      if (host_ready !== 1'b0)
        n++;
      step();
    end
    check_cycles("host_ready high while disabled", 0, n);
    apb_write(`SMC_REG_CONFIG, 32'h8000_0111);
    wait_ready(ok);
    if (ok)
      host_access(1'b0, a, '0);
    end_test("disable");

    $display("tests %0d checks %0d errors %0d", n_tests, n_checks, errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/sram_model.sv
// Asynchronous SRAM model
`timescale 1ns/10ps
`default_nettype none

`include "smc_lite_settings.svh"

module sram_model
(
  input wire logic mem_cs_n,                    // Chip select
  input wire logic mem_oe_n,                    // Output enable
  input wire logic mem_we_n,                    // Write enable
  input wire smc_lite_pkg::addr_t mem_addr,
  input wire smc_lite_pkg::data_t mem_wdata,
  output smc_lite_pkg::data_t mem_rdata
);

  smc_lite_pkg::data_t mem [0:(1 << `SMC_ADDR_W) - 1];

  // Fill, upper half scrambled from the address
  initial
  begin : p_fill
    for (int i = 0; i < (1 << `SMC_ADDR_W); i++)
      mem[16'(i)] = {16'(i) ^ 16'ha5c3, 16'(i)};
  end

  // Data latched at the end of the write pulse
  always @(posedge mem_we_n)
  begin : p_write
    mem[mem_addr] = mem_wdata;   // Address and data still held
  end

  // Read path, parked low when not selected
  assign mem_rdata = (!mem_cs_n && !mem_oe_n) ? mem[mem_addr] : '0;

endmodule

`default_nettype wire

//--- hdl/smc_lite_top.sv
// Static memory controller top level
`timescale 1ns/10ps
`default_nettype none

module smc_lite_top
(
  input wire logic pclk,                        // Single clock
  input wire logic reset,                       // Sync reset, active high
  // APB slave
  input wire logic psel,
  input wire logic penable,
  input wire logic pwrite,
  input wire logic [4:0] paddr,
  input wire smc_lite_pkg::data_t pwdata,
  output smc_lite_pkg::data_t prdata,
  // Host strobes
  input wire logic host_req,
  input wire logic host_write,
  input wire smc_lite_pkg::addr_t host_addr,
  input wire smc_lite_pkg::data_t host_wdata,
  output logic host_ready,
  output logic host_done,
  output smc_lite_pkg::data_t host_rdata,
  // SRAM pins
  output logic mem_cs_n,
  output logic mem_oe_n,
  output logic mem_we_n,
  output smc_lite_pkg::addr_t mem_addr,
  output smc_lite_pkg::data_t mem_wdata,
  input wire smc_lite_pkg::data_t mem_rdata
);

  logic cfg_wr;                        // Register 0 write strobe
  smc_lite_pkg::data_t cfg_wdata;      // Register 0 write data
  smc_lite_pkg::data_t cfg_word;       // Register 0 readback
  smc_lite_pkg::data_t status_word;    // Register 1 readback

  smc_cfg_if cfg_bus ();               // Config down, status up

  // APB decode and read mux
  smc_apb_lite_if i_apb_if
  (
    .pclk        (pclk),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .cfg_word    (cfg_word),
    .status_word (status_word),
    .prdata      (prdata),
    .cfg_wr      (cfg_wr),
    .cfg_wdata   (cfg_wdata)
  );

  smc_cfreg_lite i_cfreg
  (
    .pclk        (pclk),
    .reset       (reset),
    .cfg_wr      (cfg_wr),
    .cfg_wdata   (cfg_wdata),
    .cfg_word    (cfg_word),
    .status_word (status_word),
    .cfg_bus     (cfg_bus.cfg_side)
  );

  // SRAM strobes and host handshake
  smc_access_fsm i_access_fsm
  (
    .pclk       (pclk),
    .reset      (reset),
    .host_req   (host_req),
    .host_write (host_write),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .mem_rdata  (mem_rdata),
    .host_ready (host_ready),
    .host_done  (host_done),
    .host_rdata (host_rdata),
    .mem_cs_n   (mem_cs_n),
    .mem_oe_n   (mem_oe_n),
    .mem_we_n   (mem_we_n),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .cfg_bus    (cfg_bus.ctrl_side)
  );

endmodule

`default_nettype wire

//--- hdl/smc_access_fsm.sv
// SRAM access state machine
`timescale 1ns/10ps
`default_nettype none

module smc_access_fsm
(
  input wire logic pclk,                        // Clock
  input wire logic reset,                       // Sync reset, active high
  input wire logic host_req,                    // Request pulse
  input wire logic host_write,                  // 1 write, 0 read
  input wire smc_lite_pkg::addr_t host_addr,    // Request address
  input wire smc_lite_pkg::data_t host_wdata,   // Request write data
  input wire smc_lite_pkg::data_t mem_rdata,    // SRAM read data
  output logic host_ready,                      // Idle and enabled
  output logic host_done,                       // Access complete pulse
  output smc_lite_pkg::data_t host_rdata,       // Last read word
  output logic mem_cs_n,                        // SRAM chip select
  output logic mem_oe_n,                        // SRAM output enable
  output logic mem_we_n,                        // SRAM write enable
  output smc_lite_pkg::addr_t mem_addr,         // SRAM address
  output smc_lite_pkg::data_t mem_wdata,        // SRAM write data
  smc_cfg_if.ctrl_side cfg_bus                  // Configuration in, status out
);

  typedef enum logic [1:0]
  {
    ST_IDLE,      // Waiting for host
    ST_ACCESS,    // Strobes active
    ST_DONE,      // Done pulse
    ST_TURN       // Bus turnaround
  } state_t;

  state_t state;
  smc_lite_pkg::wait_t cnt;            // Wait or turnaround down-counter
  logic write_q;                       // Direction of current access
  smc_lite_pkg::count_t access_cnt;    // Completed accesses, wraps

  // ----------------------------------------------------------------------
  // State machine
  // ----------------------------------------------------------------------
  always_ff @(posedge pclk)
  begin : p_fsm
    if (reset)
    begin
      state <= ST_IDLE;
      cnt <= '0;
      write_q <= 1'b0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          if (host_req && host_ready)
          begin
            state <= ST_ACCESS;
            write_q <= host_write;
            // W taken now, later config writes leave this access alone
            cnt <= host_write ? cfg_bus.cfg.wr_wait : cfg_bus.cfg.rd_wait;
          end
        end
        ST_ACCESS:
        begin
          if (cnt == '0)
            state <= ST_DONE;             // W+1 strobe cycles elapsed
          else
            cnt <= cnt - smc_lite_pkg::wait_t'(1);
        end
        ST_DONE:
        begin
          if (cfg_bus.cfg.turn == '0)
            state <= ST_IDLE;             // No turnaround
          else
          begin
            state <= ST_TURN;
            cnt <= smc_lite_pkg::wait_t'(cfg_bus.cfg.turn) - smc_lite_pkg::wait_t'(1);
          end
        end
        ST_TURN:
        begin
          if (cnt == '0)
            state <= ST_IDLE;
          else
            cnt <= cnt - smc_lite_pkg::wait_t'(1);
        end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // Address and data captured with the request
  always_ff @(posedge pclk)
  begin : p_payload
    if (state == ST_IDLE && host_req && host_ready)
    begin
      mem_addr <= host_addr;
      mem_wdata <= host_wdata;
    end
    if (state == ST_ACCESS && cnt == '0 && !write_q)
      host_rdata <= mem_rdata;            // Sample at the last strobe edge
  end

  // Access counter
  always_ff @(posedge pclk)
  begin : p_count
    if (reset)
      access_cnt <= '0;
    else if (host_done)
      access_cnt <= access_cnt + smc_lite_pkg::count_t'(1);
  end

  // ----------------------------------------------------------------------
  // Outputs
  // ----------------------------------------------------------------------
  assign mem_cs_n = (state != ST_ACCESS);
  assign mem_oe_n = !(state == ST_ACCESS && !write_q);   // Read strobe
  assign mem_we_n = !(state == ST_ACCESS && write_q);    // Write strobe
  assign host_done = (state == ST_DONE);
  assign host_ready = (state == ST_IDLE) && cfg_bus.cfg.enable;

  // Status back to register block
  assign cfg_bus.busy = (state != ST_IDLE);
  assign cfg_bus.access_count = access_cnt;

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  // Accepted request opens the matching strobe in the next cycle
  a_req_strobe : assert property
  (
    @(posedge pclk) disable iff (reset)
      (host_req && host_ready) |=>
        (!mem_cs_n && mem_we_n != $past(host_write) && mem_oe_n == $past(host_write))
  )
  else $error("no SRAM strobe or wrong strobe after an accepted request");

  // Host must wait for ready
  a_req_ready : assert property
  (
    @(posedge pclk) disable iff (reset) host_req |-> host_ready
  )
  else $error("host request while host_ready is low");

  a_done_pulse : assert property
  (
    @(posedge pclk) disable iff (reset) host_done |=> !host_done
  )
  else $error("host_done high for more than one cycle");

endmodule

`default_nettype wire

//--- hdl/smc_cfreg_lite.sv
// Configuration and status registers
`timescale 1ns/10ps
`default_nettype none

`include "smc_lite_settings.svh"

module smc_cfreg_lite
(
  input wire logic pclk,                        // APB clock
  input wire logic reset,                       // Sync reset, active high
  input wire logic cfg_wr,                      // Register 0 write
  input wire smc_lite_pkg::data_t cfg_wdata,    // Register 0 write data
  output smc_lite_pkg::data_t cfg_word,         // Register 0 readback
  output smc_lite_pkg::data_t status_word,      // Register 1 readback
  smc_cfg_if.cfg_side cfg_bus                   // To access controller
);

  smc_lite_pkg::cfg_t cfg_reg;    // Stored configuration
  smc_lite_pkg::cfg_t cfg_next;   // Write data with reserved bits cleared

  // Clear reserved field of incoming word
  always_comb
  begin
    cfg_next = smc_lite_pkg::cfg_t'(cfg_wdata);
    cfg_next.rsvd = '0;
  end

  // ----------------------------------------------------------------------
  // Register 0
  // ----------------------------------------------------------------------
  always_ff @(posedge pclk)
  begin : p_cfg_reg
    if (reset)
    begin
      cfg_reg.enable <= 1'b1;                 // Ready for the host out of reset
      cfg_reg.rsvd <= '0;
      cfg_reg.turn <= `SMC_RST_TURN;
      cfg_reg.wr_wait <= `SMC_RST_WR_WAIT;
      cfg_reg.rd_wait <= `SMC_RST_RD_WAIT;
    end
    else if (cfg_wr)
      cfg_reg <= cfg_next;                    // New from the next cycle
  end

  assign cfg_word = cfg_reg;
  assign cfg_bus.cfg = cfg_reg;

  // Register 1, busy flag and access count
  always_comb
  begin : p_status
    status_word = '0;
    status_word[31] = cfg_bus.busy;
    status_word[15:0] = cfg_bus.access_count;
  end

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  // Reserved bits never set, whatever the APB side writes
  a_rsvd_zero : assert property
  (
    @(posedge pclk) disable iff (reset) cfg_reg.rsvd == '0
  )
  else $error("reserved configuration bits are not zero");

endmodule

`default_nettype wire

//--- hdl/smc_apb_lite_if.sv
// APB register slave
`timescale 1ns/10ps
`default_nettype none

`include "smc_lite_settings.svh"

module smc_apb_lite_if
(
  input wire logic pclk,                          // APB clock, checks only
  input wire logic psel,                          // APB select
  input wire logic penable,                       // APB enable
  input wire logic pwrite,                        // APB write strobe
  input wire logic [4:0] paddr,                   // APB address
  input wire smc_lite_pkg::data_t pwdata,         // APB write data
  input wire smc_lite_pkg::data_t cfg_word,       // Register 0 contents
  input wire smc_lite_pkg::data_t status_word,    // Register 1 contents
  output smc_lite_pkg::data_t prdata,             // APB read data
  output logic cfg_wr,                            // Register 0 write strobe
  output smc_lite_pkg::data_t cfg_wdata           // Register 0 write data
);

  logic sel_config;   // Register 0 selected in access phase
  logic sel_status;   // Register 1 selected in access phase

  // ----------------------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------------------
  always_comb
  begin : p_addr_decode
    sel_config = 1'b0;
    sel_status = 1'b0;
    if (psel && penable)   // Access phase only
    begin
      if (paddr == `SMC_REG_CONFIG)
        sel_config = 1'b1;
      else if (paddr == `SMC_REG_STATUS)
        sel_status = 1'b1;
    end
  end

  // Write path, status is read only
  assign cfg_wr = sel_config & pwrite;
  assign cfg_wdata = pwdata;   // Masked in the register block

  // Read mux
  always_comb
  begin : p_read_mux
    if (sel_config)
      prdata = cfg_word;
    else if (sel_status)
      prdata = status_word;
    else
      prdata = '0;   // Unmapped or no access
  end

  // ----------------------------------------------------------------------
  // Protocol checks
  // ----------------------------------------------------------------------
  // Address held from setup into access phase
  a_paddr_stable : assert property
  (
    @(posedge pclk) (psel && penable) |-> $stable(paddr)
  )
  else $error("paddr changed between APB setup and access phase");

endmodule

`default_nettype wire

//--- hdl/smc_cfg_if.sv
// Configuration and status link
`timescale 1ns/10ps
`default_nettype none

interface smc_cfg_if;

  // Register block to access controller
  smc_lite_pkg::cfg_t cfg;                // Live register 0 contents

  // Access controller back to register block
  logic busy;                             // Not idle
  smc_lite_pkg::count_t access_count;     // Completed accesses

  // Register side
  modport cfg_side
  (
    output cfg,
    input busy,
    input access_count
  );

  // Controller side
  modport ctrl_side
  (
    input cfg,
    output busy,
    output access_count
  );

endinterface

`default_nettype wire

//--- hdl/smc_lite_pkg.sv
// Static memory controller types
`default_nettype none

`include "smc_lite_settings.svh"

package smc_lite_pkg;

  // Field types
  typedef logic [`SMC_WAIT_W-1:0] wait_t;     // Wait states per access
  typedef logic [`SMC_TURN_W-1:0] turn_t;     // Idle cycles after access
  typedef logic [`SMC_COUNT_W-1:0] count_t;   // Wrapping access count

  // Bus words
  typedef logic [`SMC_DATA_W-1:0] data_t;
  typedef logic [`SMC_ADDR_W-1:0] addr_t;

  // ----------------------------------------------------------------------
  // Register 0 layout
  // ----------------------------------------------------------------------
  // enable in bit 31, turn in 9:8, wr_wait in 7:4, rd_wait in 3:0
  typedef struct packed
  {
    logic enable;                                             // Accept host requests
    logic [`SMC_DATA_W-2-`SMC_TURN_W-2*`SMC_WAIT_W:0] rsvd;   // Always zero
    turn_t turn;
    wait_t wr_wait;
    wait_t rd_wait;
  } cfg_t;

  // Register 1 layout is built in the register block
  // busy in bit 31, count in 15:0

endpackage

`default_nettype wire

//--- hdl/smc_lite_settings.svh
// Static memory controller settings
`ifndef SMC_LITE_SETTINGS_SVH
`define SMC_LITE_SETTINGS_SVH

// ----------------------------------------------------------------------
// Bus widths
// ----------------------------------------------------------------------
`define SMC_ADDR_W 16                // SRAM address bits
`define SMC_DATA_W 32                // SRAM and APB data bits

// Register field widths
`define SMC_WAIT_W 4                 // Wait-state count
`define SMC_TURN_W 2                 // Turnaround count
`define SMC_COUNT_W 16               // Completed access counter

// ----------------------------------------------------------------------
// APB register map, 5-bit address
// ----------------------------------------------------------------------
`define SMC_REG_CONFIG 5'h00         // Register 0, configuration
`define SMC_REG_STATUS 5'h04         // Register 1, status

// Configuration defaults after reset
`define SMC_RST_RD_WAIT 4'd3
`define SMC_RST_WR_WAIT 4'd2
`define SMC_RST_TURN 2'd1

`endif
